/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_retire_core
FILELIST  = retire_core.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

/* common/retire_cfg.svh */
// retirement back end configuration
`ifndef RETIRE_CFG_SVH
`define RETIRE_CFG_SVH

// reorder buffer entries, power of two and at least 4
`define ROB_DEPTH 8

// data and pc width
`define XLEN 32

// architectural registers, r0 reads as zero
`define ARCH_REGS 16

// redirect target taken on an exception
`define EXC_VECTOR 32'h0000_0100

`endif

/* common/retire_pkg.sv */
// retirement types
`include "retire_cfg.svh"

package retire_pkg;

  // ==============================
  // instruction kinds
  // ==============================
  typedef enum logic [1:0] {
    KIND_ALU    = 2'd0,
    KIND_BRANCH = 2'd1,
    KIND_LOAD   = 2'd2,
    KIND_STORE  = 2'd3
  } instr_kind_e;

  // ==============================
  // result word
  // ==============================

  // branch view, target bit 0 is implied zero
  typedef struct packed {
    logic [`XLEN-2:0] target;
    logic             redirect;
  } rob_br_word_t;

  // register value for alu/load, branch view for branches
  typedef union packed {
    logic [`XLEN-1:0] value;
    rob_br_word_t     br;
  } rob_result_u;

  // ==============================
  // reorder buffer entry
  // ==============================
  typedef struct packed {
    logic                           complete;
    instr_kind_e                    kind;
    logic [`XLEN-1:0]               pc;
    logic [$clog2(`ARCH_REGS)-1:0]  rd;
    // fault raised at dispatch or by the memory port
    logic                           excp;
    rob_result_u                    result;
  } rob_entry_t;

endpackage

/* retire_core.f */
+incdir+common
common/retire_pkg.sv
rob/reorder_buffer.sv
rob/commit_select.sv
verilog/retire_unit.sv
verilog/retire_core.sv
verification/tb_retire_core.sv

/* rob/commit_select.sv */
// two-slot commit selection
`include "retire_cfg.svh"

module commit_select (
  input  retire_pkg::rob_entry_t       head_entry0,
  input  retire_pkg::rob_entry_t       head_entry1,
  input  logic [$clog2(`ROB_DEPTH):0]  rob_count,
  input  logic                         flush,
  output logic [1:0]                   commit_valid
);

  localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

  // ==============================
  // per-slot status
  // ==============================
  logic has_one;
  logic has_two;
  logic branch0;
  logic branch1;
  logic redirect0;
  logic redirect1;
  logic stop0;
  logic stop1;
  logic pair_ok;

  // occupancy
  assign has_one = rob_count != '0;
  assign has_two = rob_count >= CNT_W'(2);

  assign branch0 = head_entry0.kind == retire_pkg::KIND_BRANCH;
  assign branch1 = head_entry1.kind == retire_pkg::KIND_BRANCH;

  // redirect flag only means something for a branch
  assign redirect0 = branch0 && head_entry0.result.br.redirect;
  assign redirect1 = branch1 && head_entry1.result.br.redirect;

  // entries that end the retire group
  assign stop0 = head_entry0.excp || redirect0;
  assign stop1 = head_entry1.excp || redirect1;

  // ==============================
  // selection
  // ==============================

  // one branch per cycle, faults and redirects retire alone
  assign pair_ok = !stop0 && !stop1 && !branch0;

  assign commit_valid[0] = has_one && head_entry0.complete && !flush;
  assign commit_valid[1] = commit_valid[0] && has_two && head_entry1.complete && pair_ok;

endmodule

/* rob/reorder_buffer.sv */
// reorder buffer entry array
`include "retire_cfg.svh"

module reorder_buffer (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush,
  // dispatch
  input  logic [1:0]                                disp_valid,
  input  logic [1:0][`XLEN-1:0]                     disp_pc,
  input  retire_pkg::instr_kind_e [1:0]             disp_kind,
  input  logic [1:0][$clog2(`ARCH_REGS)-1:0]        disp_rd,
  input  logic [1:0]                                disp_excp,
  output logic                                      disp_ready,
  output logic [1:0][$clog2(`ROB_DEPTH)-1:0]        disp_rob_idx,
  // alu/branch writeback
  input  logic [1:0]                                wb_valid,
  input  logic [1:0][$clog2(`ROB_DEPTH)-1:0]        wb_rob_idx,
  input  logic [1:0][`XLEN-1:0]                     wb_result,
  // memory writeback
  input  logic                                      mem_valid,
  input  logic [$clog2(`ROB_DEPTH)-1:0]             mem_rob_idx,
  input  logic [`XLEN-1:0]                          mem_result,
  input  logic                                      mem_excp,
  output logic                                      mem_ready,
  // commit
  input  logic [1:0]                                commit_valid,
  output retire_pkg::rob_entry_t                    head_entry0,
  output retire_pkg::rob_entry_t                    head_entry1,
  output logic [$clog2(`ROB_DEPTH):0]               rob_count
);

  localparam int IDX_W = $clog2(`ROB_DEPTH);

  // ==============================
  // state
  // ==============================
  retire_pkg::rob_entry_t rob_q [`ROB_DEPTH];
  retire_pkg::rob_entry_t rob_n [`ROB_DEPTH];

  // pointers carry a wrap bit above the index
  logic [IDX_W:0]   head_ptr;
  logic [IDX_W:0]   tail_ptr;
  logic [IDX_W:0]   rob_cnt;

  logic [IDX_W-1:0] head_idx;
  logic [IDX_W-1:0] head_idx1;
  logic [1:0]       alloc_en;
  logic [1:0]       alloc_cnt;
  logic [1:0]       commit_cnt;

  // memory port qualification
  logic [IDX_W-1:0] mem_offset;
  logic             mem_in_flight;
  logic             mem_is_load;

  // ==============================
  // allocation
  // ==============================

  // room for a full pair, closed during the flush cycle
  assign disp_ready = (rob_cnt <= (IDX_W+1)'(`ROB_DEPTH - 2)) && !flush;
  assign alloc_en   = disp_valid & {2{disp_ready}};
  assign alloc_cnt  = {1'b0, alloc_en[0]} + {1'b0, alloc_en[1]};

  // slot 1 packs behind slot 0 only when slot 0 is used
  assign disp_rob_idx[0] = tail_ptr[IDX_W-1:0];
  assign disp_rob_idx[1] = tail_ptr[IDX_W-1:0] + IDX_W'(disp_valid[0]);

  // ==============================
  // head and commit
  // ==============================
  assign head_idx    = head_ptr[IDX_W-1:0];
  assign head_idx1   = head_idx + IDX_W'(1);
  assign head_entry0 = rob_q[head_idx];
  assign head_entry1 = rob_q[head_idx1];
  assign rob_count   = rob_cnt;
  assign commit_cnt  = {1'b0, commit_valid[0]} + {1'b0, commit_valid[1]};

  // ==============================
  // memory port ready
  // ==============================

  // distance from head tells whether the index is live
  assign mem_offset    = mem_rob_idx - head_idx;
  assign mem_in_flight = {1'b0, mem_offset} < rob_cnt;
  assign mem_is_load   = rob_q[mem_rob_idx].kind == retire_pkg::KIND_LOAD;

  // stores only complete once they are the oldest
  assign mem_ready = mem_in_flight && (mem_is_load || (mem_rob_idx == head_idx));

  // ==============================
  // next-state array
  // ==============================
  always_comb begin
    rob_n = rob_q;

    // new entries
    for (int i = 0; i < 2; i++) begin
      if (alloc_en[i]) begin
        rob_n[disp_rob_idx[i]].complete     = disp_excp[i];
        rob_n[disp_rob_idx[i]].kind         = disp_kind[i];
        rob_n[disp_rob_idx[i]].pc           = disp_pc[i];
        rob_n[disp_rob_idx[i]].rd           = disp_rd[i];
        rob_n[disp_rob_idx[i]].excp         = disp_excp[i];
        rob_n[disp_rob_idx[i]].result.value = '0;
      end
    end

    // alu and branch results, never back-pressured
    for (int i = 0; i < 2; i++) begin
      if (wb_valid[i]) begin
        rob_n[wb_rob_idx[i]].complete     = 1'b1;
        rob_n[wb_rob_idx[i]].result.value = wb_result[i];
      end
    end

    // memory result may also carry a fault
    if (mem_valid && mem_ready) begin
      rob_n[mem_rob_idx].complete     = 1'b1;
      rob_n[mem_rob_idx].excp         = mem_excp;
      rob_n[mem_rob_idx].result.value = mem_result;
    end
  end

  // ==============================
  // registers
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      rob_cnt  <= '0;
    end else if (flush) begin
      // drop every in-flight entry
      head_ptr <= '0;
      tail_ptr <= '0;
      rob_cnt  <= '0;
    end else begin
      head_ptr <= head_ptr + (IDX_W+1)'(commit_cnt);
      tail_ptr <= tail_ptr + (IDX_W+1)'(alloc_cnt);
      rob_cnt  <= rob_cnt + (IDX_W+1)'(alloc_cnt) - (IDX_W+1)'(commit_cnt);
    end
  end

  always_ff @(posedge clk) begin
    rob_q <= rob_n;
  end

endmodule

/* verification/tb_retire_core.sv */
// retirement back end testbench
`include "retire_cfg.svh"

module tb_retire_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IDX_W = $clog2(`ROB_DEPTH);
  localparam int RD_W  = $clog2(`ARCH_REGS);
  // six short tests, none longer than about 100 cycles
  localparam int MAX_CYCLES = 2000;

  typedef struct {
    logic [`XLEN-1:0]        pc;
    retire_pkg::instr_kind_e kind;
    logic [RD_W-1:0]         rd;
    logic                    excp;
    logic [`XLEN-1:0]        value;
    logic [IDX_W-1:0]        idx;
  } ref_entry_t;

  logic clk;
  logic rst_n;
  logic [1:0]                          disp_valid;
  logic [1:0][`XLEN-1:0]               disp_pc;
  retire_pkg::instr_kind_e [1:0]       disp_kind;
  logic [1:0][RD_W-1:0]                disp_rd;
  logic [1:0]                          disp_excp;
  logic                                disp_ready;
  logic [1:0][IDX_W-1:0]               disp_rob_idx;
  logic [1:0]                          wb_valid;
  logic [1:0][IDX_W-1:0]               wb_rob_idx;
  logic [1:0][`XLEN-1:0]               wb_result;
  logic                                mem_valid;
  logic [IDX_W-1:0]                    mem_rob_idx;
  logic [`XLEN-1:0]                    mem_result;
  logic                                mem_excp;
  logic                                mem_ready;
  logic [1:0]                          retire_valid;
  logic [1:0][`XLEN-1:0]               retire_pc;
  logic                                flush;
  logic [`XLEN-1:0]                    redirect_pc;
  logic [RD_W-1:0]                     arch_raddr;
  logic [`XLEN-1:0]                    arch_rdata;
  logic [15:0]                         retire_count;

  // reference model state
  ref_entry_t       ref_q[$];
  logic [`XLEN-1:0] shadow [`ARCH_REGS];
  logic [`XLEN-1:0] exp_rdata;
  logic [`XLEN-1:0] exp_pc0;
  logic [`XLEN-1:0] exp_pc1;
  logic [`XLEN-1:0] redir_exp;
  logic             exp_stop0;
  logic             exp_br0;
  logic [IDX_W-1:0] exp_tail;
  int               exp_cnt;
  int               ret_total;
  int               errors;
  int               errors_mark;
  int               test_no;
  int               seed;
  logic [`XLEN-1:0] next_pc;

  retire_core dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, a test did not finish", MAX_CYCLES);
    $display("Regression failed");
    $finish;
  end

  // ==============================
  // reference model
  // ==============================
  function automatic logic is_stop(ref_entry_t e);
    return e.excp || ((e.kind == retire_pkg::KIND_BRANCH) && e.value[0]);
  endfunction

  function automatic int find_ref(logic [IDX_W-1:0] idx);
    for (int p = ref_q.size() - 1; p >= 0; p--) begin
      if (ref_q[p].idx == idx) return p;
    end
    return -1;
  endfunction

  assign exp_rdata = (arch_raddr == '0) ? '0 : shadow[arch_raddr];

  // retirements seen in the cycle that ends at this edge
  always @(posedge clk) begin
    ref_entry_t e;
    if (rst_n) begin
      for (int i = 0; i < 2; i++) begin
        if (retire_valid[i] && ref_q.size() > 0) begin
          e = ref_q.pop_front();
          ret_total++;
          if (!e.excp && e.rd != '0 && (e.kind == retire_pkg::KIND_ALU ||
                                        e.kind == retire_pkg::KIND_LOAD)) begin
            shadow[e.rd] = e.value;
          end
          if (is_stop(e)) begin
            redir_exp = e.excp ? `EXC_VECTOR : {e.value[`XLEN-1:1], 1'b0};
            ref_q.delete();
            // the flush that follows rewinds the tail
            exp_tail = '0;
          end
        end
      end
    end
    exp_cnt   = ref_q.size();
    exp_pc0   = (exp_cnt > 0) ? ref_q[0].pc : '0;
    exp_pc1   = (exp_cnt > 1) ? ref_q[1].pc : '0;
    exp_stop0 = (exp_cnt > 0) ? is_stop(ref_q[0]) : 1'b0;
    exp_br0   = (exp_cnt > 0) ? (ref_q[0].kind == retire_pkg::KIND_BRANCH) : 1'b0;
  end

  // ==============================
  // checks, sampled mid-cycle
  // ==============================
  a_pc0: assert property (@(negedge clk) disable iff (!rst_n)
    retire_valid[0] |-> (exp_cnt > 0 && retire_pc[0] == exp_pc0))
    else begin
      errors++;
      $display("Fail %0t retire_pc[0] exp %h got %h", $time, exp_pc0, retire_pc[0]);
    end
  a_pc1: assert property (@(negedge clk) disable iff (!rst_n)
    retire_valid[1] |-> (exp_cnt > 1 && retire_pc[1] == exp_pc1))
    else begin
      errors++;
      $display("Fail %0t retire_pc[1] exp %h got %h", $time, exp_pc1, retire_pc[1]);
    end
  a_one_branch: assert property (@(negedge clk) disable iff (!rst_n)
    (retire_valid[0] && exp_br0) |-> !retire_valid[1])
    else begin
      errors++;
      $display("Fail %0t retire_valid[1] exp 0 got %b", $time, retire_valid[1]);
    end
  a_flush: assert property (@(negedge clk) disable iff (!rst_n)
    (retire_valid[0] && exp_stop0) |=> (flush && redirect_pc == redir_exp))
    else begin
      errors++;
      $display("Fail %0t redirect_pc exp %h got %h (flush %b)", $time, redir_exp,
               redirect_pc, flush);
    end
  a_quiet: assert property (@(negedge clk) disable iff (!rst_n)
    flush |-> (retire_valid == 2'b00 && !disp_ready))
    else begin
      errors++;
      $display("Fail %0t retire_valid exp 00 got %b, disp_ready exp 0 got %b in flush cycle",
               $time, retire_valid, disp_ready);
    end
  a_rdata: assert property (@(negedge clk) disable iff (!rst_n) arch_rdata == exp_rdata)
    else begin
      errors++;
      $display("Fail %0t arch_rdata exp %h got %h", $time, exp_rdata, arch_rdata);
    end
  a_count: assert property (@(negedge clk) disable iff (!rst_n)
    retire_count == 16'(ret_total))
    else begin
      errors++;
      $display("Fail %0t retire_count exp %0d got %0d", $time, ret_total, retire_count);
    end

  // ==============================
  // stimulus tasks
  // ==============================
  function automatic logic [`XLEN-1:0] rand_word();
    return `XLEN'($random(seed));
  endfunction

  function automatic logic [`XLEN-1:0] branch_word(logic redirect);
    logic [`XLEN-1:0] w;
    w = rand_word();
    return {w[`XLEN-1:1], redirect};
  endfunction

  task automatic dispatch_pair(input logic [1:0] v, input retire_pkg::instr_kind_e k0,
                               input retire_pkg::instr_kind_e k1, input logic [1:0] excp,
                               output logic [IDX_W-1:0] idx0, output logic [IDX_W-1:0] idx1,
                               output logic taken);
    ref_entry_t            e;
    logic [1:0][IDX_W-1:0] exp_idx;
    disp_valid   = v;
    disp_kind[0] = k0;
    disp_kind[1] = k1;
    disp_excp    = excp;
    disp_pc[0]   = next_pc;
    disp_pc[1]   = next_pc + `XLEN'(4);
    disp_rd[0]   = RD_W'($random(seed));
    disp_rd[1]   = RD_W'($random(seed));
    #1;
    // valid slots pack from the tail, slot 0 first
    exp_idx[0] = exp_tail;
    exp_idx[1] = exp_tail + IDX_W'(v[0]);
    taken = disp_ready;
    idx0  = exp_idx[0];
    idx1  = exp_idx[1];
    if (disp_ready) begin
      next_pc = next_pc + `XLEN'(8);
      for (int i = 0; i < 2; i++) begin
        if (v[i]) begin
          assert (disp_rob_idx[i] == exp_idx[i])
            else begin
              errors++;
              $display("Fail %0t disp_rob_idx[%0d] exp %0d got %0d", $time, i,
                       exp_idx[i], disp_rob_idx[i]);
            end
          e.pc    = disp_pc[i];
          e.kind  = disp_kind[i];
          e.rd    = disp_rd[i];
          e.excp  = excp[i];
          e.value = '0;
          e.idx   = exp_idx[i];
          ref_q.push_back(e);
          exp_tail = exp_tail + IDX_W'(1);
        end
      end
    end
    @(negedge clk);
    disp_valid = '0;
    disp_excp  = '0;
  endtask

  task automatic writeback(input logic [1:0] v, input logic [IDX_W-1:0] idx0,
                           input logic [IDX_W-1:0] idx1, input logic [`XLEN-1:0] r0,
                           input logic [`XLEN-1:0] r1);
    int p;
    wb_valid      = v;
    wb_rob_idx[0] = idx0;
    wb_rob_idx[1] = idx1;
    wb_result[0]  = r0;
    wb_result[1]  = r1;
    for (int i = 0; i < 2; i++) begin
      p = find_ref(wb_rob_idx[i]);
      if (v[i] && p >= 0) ref_q[p].value = wb_result[i];
    end
    @(negedge clk);
    wb_valid = '0;
  endtask

  task automatic mem_writeback(input logic [IDX_W-1:0] idx, input logic [`XLEN-1:0] data,
                               input logic excp, output logic taken);
    int p;
    mem_valid   = 1'b1;
    mem_rob_idx = idx;
    mem_result  = data;
    mem_excp    = excp;
    #1;
    taken = mem_ready;
    p = find_ref(idx);
    if (taken && p >= 0) begin
      ref_q[p].value = data;
      ref_q[p].excp  = excp;
    end
    @(negedge clk);
    mem_valid = 1'b0;
  endtask

  task automatic wait_retire();
    while (!retire_valid[0]) @(negedge clk);
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (ref_q.size() != 0 || flush) @(negedge clk);
  endtask

  task automatic sweep_regs();
    for (int r = 0; r < `ARCH_REGS; r++) begin
      arch_raddr = RD_W'(r);
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name);
    test_no++;
    $display("test %0d %s done, %0d errors", test_no, name, errors - errors_mark);
    errors_mark = errors;
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial begin
    logic [IDX_W-1:0] ids [8];
    logic [IDX_W-1:0] i0;
    logic [IDX_W-1:0] i1;
    logic [IDX_W-1:0] i2;
    logic [IDX_W-1:0] i3;
    logic             ok;
    seed = 99;
    errors = 0;
    errors_mark = 0;
    test_no = 0;
    ret_total = 0;
    exp_cnt = 0;
    exp_tail = '0;
    next_pc = `XLEN'(32'h1000);
    for (int r = 0; r < `ARCH_REGS; r++) shadow[r] = '0;
    rst_n = 1'b0;
    disp_valid = '0;
    disp_pc = '0;
    disp_kind[0] = retire_pkg::KIND_ALU;
    disp_kind[1] = retire_pkg::KIND_ALU;
    disp_rd = '0;
    disp_excp = '0;
    wb_valid = '0;
    wb_rob_idx = '0;
    wb_result = '0;
    mem_valid = 1'b0;
    mem_rob_idx = '0;
    mem_result = '0;
    mem_excp = 1'b0;
    arch_raddr = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // results arrive youngest first
    for (int p = 0; p < 4; p++) begin
      dispatch_pair(2'b11, retire_pkg::KIND_ALU, retire_pkg::KIND_ALU, 2'b00,
                    ids[2*p], ids[2*p+1], ok);
    end
    for (int p = 3; p >= 0; p--) begin
      writeback(2'b11, ids[2*p+1], ids[2*p], rand_word(), rand_word());
    end
    wait_idle();
    sweep_regs();
    finish_test("in_order");

    dispatch_pair(2'b11, retire_pkg::KIND_ALU, retire_pkg::KIND_ALU, 2'b00, i0, i1, ok);
    writeback(2'b11, i0, i1, rand_word(), rand_word());
    wait_retire();
    assert (retire_valid == 2'b11)
      else begin
        errors++;
        $display("Fail %0t retire_valid exp 11 got %b", $time, retire_valid);
      end
    wait_idle();
    dispatch_pair(2'b11, retire_pkg::KIND_BRANCH, retire_pkg::KIND_ALU, 2'b00, i0, i1, ok);
    writeback(2'b11, i0, i1, branch_word(1'b0), rand_word());
    wait_retire();
    assert (retire_valid == 2'b01)
      else begin
        errors++;
        $display("Fail %0t retire_valid exp 01 got %b", $time, retire_valid);
      end
    wait_idle();
    finish_test("retire_width");

    // younger entries are complete before the branch resolves
    dispatch_pair(2'b11, retire_pkg::KIND_BRANCH, retire_pkg::KIND_ALU, 2'b00, i0, i1, ok);
    dispatch_pair(2'b11, retire_pkg::KIND_ALU, retire_pkg::KIND_ALU, 2'b00, i2, i3, ok);
    writeback(2'b11, i2, i3, rand_word(), rand_word());
    writeback(2'b01, i1, i1, rand_word(), '0);
    writeback(2'b01, i0, i0, branch_word(1'b1), '0);
    wait_idle();
    sweep_regs();
    finish_test("branch_redirect");

    // fault in slot 1, complete neighbours on both sides
    dispatch_pair(2'b11, retire_pkg::KIND_ALU, retire_pkg::KIND_ALU, 2'b10, i0, i1, ok);
    dispatch_pair(2'b11, retire_pkg::KIND_ALU, retire_pkg::KIND_ALU, 2'b00, i2, i3, ok);
    writeback(2'b11, i2, i3, rand_word(), rand_word());
    writeback(2'b01, i0, i0, rand_word(), '0);
    wait_idle();
    sweep_regs();
    finish_test("exception");

    dispatch_pair(2'b11, retire_pkg::KIND_ALU, retire_pkg::KIND_STORE, 2'b00, i0, i1, ok);
    dispatch_pair(2'b11, retire_pkg::KIND_LOAD, retire_pkg::KIND_ALU, 2'b00, i2, i3, ok);
    mem_writeback(i2, rand_word(), 1'b0, ok);
    assert (ok)
      else begin
        errors++;
        $display("Fail %0t mem_ready exp 1 got 0 for a load", $time);
      end
    mem_writeback(i1, rand_word(), 1'b0, ok);
    assert (!ok)
      else begin
        errors++;
        $display("Fail %0t mem_ready exp 0 got 1 for a store behind the head", $time);
      end
    writeback(2'b11, i0, i3, rand_word(), rand_word());
    do begin
      mem_writeback(i1, rand_word(), 1'b0, ok);
    end while (!ok);
    wait_idle();
    sweep_regs();
    finish_test("memory_order");

    for (int p = 0; p < 3; p++) begin
      dispatch_pair(2'b11, retire_pkg::KIND_ALU, retire_pkg::KIND_ALU, 2'b00,
                    ids[2*p], ids[2*p+1], ok);
    end
    dispatch_pair(2'b01, retire_pkg::KIND_ALU, retire_pkg::KIND_ALU, 2'b00, ids[6], i1, ok);
    assert (ok)
      else begin
        errors++;
        $display("Fail %0t disp_ready exp 1 got 0 with six entries in flight", $time);
      end
    dispatch_pair(2'b11, retire_pkg::KIND_ALU, retire_pkg::KIND_ALU, 2'b00, i0, i1, ok);
    assert (!ok)
      else begin
        errors++;
        $display("Fail %0t disp_ready exp 0 got 1 with seven entries in flight", $time);
      end
    writeback(2'b01, ids[0], ids[0], rand_word(), '0);
    while (!disp_ready) @(negedge clk);
    for (int p = 0; p < 3; p++) begin
      writeback(2'b11, ids[2*p+1], ids[2*p+2], rand_word(), rand_word());
    end
    wait_idle();
    sweep_regs();
    finish_test("back_pressure");

    $display("%0d tests run, %0d errors", test_no, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog/retire_core.sv */
// retirement back end top
`include "retire_cfg.svh"

module retire_core (
  input  logic                                clk,
  input  logic                                rst_n,
  // dispatch
  input  logic [1:0]                          disp_valid,
  input  logic [1:0][`XLEN-1:0]               disp_pc,
  input  retire_pkg::instr_kind_e [1:0]       disp_kind,
  input  logic [1:0][$clog2(`ARCH_REGS)-1:0]  disp_rd,
  input  logic [1:0]                          disp_excp,
  output logic                                disp_ready,
  output logic [1:0][$clog2(`ROB_DEPTH)-1:0]  disp_rob_idx,
  // alu/branch writeback
  input  logic [1:0]                          wb_valid,
  input  logic [1:0][$clog2(`ROB_DEPTH)-1:0]  wb_rob_idx,
  input  logic [1:0][`XLEN-1:0]               wb_result,
  // memory writeback
  input  logic                                mem_valid,
  input  logic [$clog2(`ROB_DEPTH)-1:0]       mem_rob_idx,
  input  logic [`XLEN-1:0]                    mem_result,
  input  logic                                mem_excp,
  output logic                                mem_ready,
  // retirement
  output logic [1:0]                          retire_valid,
  output logic [1:0][`XLEN-1:0]               retire_pc,
  output logic                                flush,
  output logic [`XLEN-1:0]                    redirect_pc,
  input  logic [$clog2(`ARCH_REGS)-1:0]       arch_raddr,
  output logic [`XLEN-1:0]                    arch_rdata,
  output logic [15:0]                         retire_count
);

  retire_pkg::rob_entry_t          head_entry0;
  retire_pkg::rob_entry_t          head_entry1;
  logic [$clog2(`ROB_DEPTH):0]     rob_count;
  logic [1:0]                      commit_valid;

  reorder_buffer u_rob (
    .clk, .rst_n, .flush,
    .disp_valid, .disp_pc, .disp_kind, .disp_rd, .disp_excp, .disp_ready, .disp_rob_idx,
    .wb_valid, .wb_rob_idx, .wb_result,
    .mem_valid, .mem_rob_idx, .mem_result, .mem_excp, .mem_ready,
    .commit_valid, .head_entry0, .head_entry1, .rob_count
  );

  commit_select u_commit_select (
    .head_entry0, .head_entry1, .rob_count, .flush, .commit_valid
  );

  retire_unit u_retire_unit (
    .clk, .rst_n, .commit_valid, .head_entry0, .head_entry1, .arch_raddr,
    .flush, .redirect_pc, .retire_valid, .retire_pc, .arch_rdata, .retire_count
  );

endmodule

/* verilog/retire_unit.sv */
// architectural retirement
`include "retire_cfg.svh"

module retire_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [1:0]                     commit_valid,
  input  retire_pkg::rob_entry_t         head_entry0,
  input  retire_pkg::rob_entry_t         head_entry1,
  input  logic [$clog2(`ARCH_REGS)-1:0]  arch_raddr,
  output logic                           flush,
  output logic [`XLEN-1:0]               redirect_pc,
  output logic [1:0]                     retire_valid,
  output logic [1:0][`XLEN-1:0]          retire_pc,
  output logic [`XLEN-1:0]               arch_rdata,
  output logic [15:0]                    retire_count
);

  retire_pkg::rob_entry_t slot [2];
  logic [1:0]             slot_we;
  logic [1:0]             slot_redir;
  logic                   flush_d;
  logic [`XLEN-1:0]       redirect_pc_d;
  logic [`XLEN-1:0]       arf [`ARCH_REGS];

  assign slot[0] = head_entry0;
  assign slot[1] = head_entry1;

  // ==============================
  // per-slot decode
  // ==============================
  for (genvar i = 0; i < 2; i++) begin : g_slot
    // faulting entries leave the register file alone
    assign slot_we[i] = commit_valid[i] && !slot[i].excp && (slot[i].rd != '0) &&
                        ((slot[i].kind == retire_pkg::KIND_ALU) ||
                         (slot[i].kind == retire_pkg::KIND_LOAD));
    assign slot_redir[i] = commit_valid[i] &&
                           (slot[i].excp || ((slot[i].kind == retire_pkg::KIND_BRANCH) &&
                                             slot[i].result.br.redirect));
    assign retire_pc[i] = slot[i].pc;
  end

  assign retire_valid = commit_valid;

  // oldest redirecting slot picks the target
  always_comb begin
    flush_d       = 1'b0;
    redirect_pc_d = '0;
    for (int i = 1; i >= 0; i--) begin
      if (slot_redir[i]) begin
        flush_d       = 1'b1;
        redirect_pc_d = slot[i].excp ? `EXC_VECTOR : {slot[i].result.br.target, 1'b0};
      end
    end
  end

  // ==============================
  // flush and counters
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush        <= 1'b0;
      retire_count <= '0;
    end else begin
      flush        <= flush_d;
      retire_count <= retire_count + 16'(commit_valid[0]) + 16'(commit_valid[1]);
    end
  end

  always_ff @(posedge clk) begin
    if (flush_d) begin
      redirect_pc <= redirect_pc_d;
    end
  end

  // ==============================
  // register file
  // ==============================

  // slot 1 written last so it wins on a shared rd
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `ARCH_REGS; r++) begin
        arf[r] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (slot_we[i]) begin
          arf[slot[i].rd] <= slot[i].result.value;
        end
      end
    end
  end

  assign arch_rdata = (arch_raddr == '0) ? '0 : arf[arch_raddr];

endmodule
